/* hw/alut_addr_checker.sv */
//--------------------------------------------------------------------
// frame engine: learn source mac, look up destination mac
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker
(
   input  logic                          pclk30,
   input  logic                          n_p_reset30,
   alut_mem_if.requester                 mem,
   input  logic                          frm_req,        // frame to process
   output logic                          frm_ack,        // result ready
   input  logic [47:0]                   src_mac,
   input  logic [1:0]                    src_port,
   input  logic [47:0]                   dst_mac,
   output logic                          dst_hit,
   output logic [1:0]                    dst_port,
   input  logic [alut_pkg::ALUT_TW-1:0]  curr_time,
   output logic                          age_req,        // age query to age checker
   input  logic                          age_ack,
   output logic [alut_pkg::ALUT_TW-1:0]  last_accessed,
   input  logic                          age_ok
);
   import alut_pkg::*;

   localparam logic [2:0] ST_IDLE    = 3'd0;
   localparam logic [2:0] ST_WR      = 3'd1;   // learn write in flight
   localparam logic [2:0] ST_WR_REL  = 3'd2;
   localparam logic [2:0] ST_RD      = 3'd3;   // lookup read in flight
   localparam logic [2:0] ST_RD_REL  = 3'd4;
   localparam logic [2:0] ST_AGE     = 3'd5;   // waiting on age checker
   localparam logic [2:0] ST_AGE_REL = 3'd6;
   localparam logic [2:0] ST_DONE    = 3'd7;   // frm_ack high

   logic [2:0]   state;
   alut_entry_t  rd_entry;    // destination word as read
   logic         dst_match;   // valid entry with the right mac

   assign dst_match     = rd_entry.valid && (rd_entry.mac == dst_mac);
   assign last_accessed = rd_entry.stamp;
   assign dst_port      = rd_entry.port;

   //--------------------------------------------------------------------
   // frame FSM
   //--------------------------------------------------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         state     <= ST_IDLE;
         mem.req   <= 1'b0;
         mem.write <= 1'b0;
         age_req   <= 1'b0;
         frm_ack   <= 1'b0;
         dst_hit   <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (frm_req)
               begin
                  mem.req   <= 1'b1;          // source learn goes first
                  mem.write <= 1'b1;
                  state     <= ST_WR;
               end
            ST_WR:
               if (mem.ack)
               begin
                  mem.req <= 1'b0;
                  state   <= ST_WR_REL;
               end
            ST_WR_REL:
               if (!mem.ack)
               begin
                  mem.req   <= 1'b1;          // then the destination read
                  mem.write <= 1'b0;
                  state     <= ST_RD;
               end
            ST_RD:
               if (mem.ack)
               begin
                  mem.req <= 1'b0;
                  state   <= ST_RD_REL;
               end
            ST_RD_REL:
               if (!mem.ack)
               begin
                  if (dst_match)
                  begin
                     age_req <= 1'b1;         // found, is it still fresh
                     state   <= ST_AGE;
                  end
                  else
                  begin
                     dst_hit <= 1'b0;         // empty or other mac
                     frm_ack <= 1'b1;
                     state   <= ST_DONE;
                  end
               end
            ST_AGE:
               if (age_ack)
               begin
                  age_req <= 1'b0;
                  dst_hit <= age_ok;
                  state   <= ST_AGE_REL;
               end
            ST_AGE_REL:
               if (!age_ack)
               begin
                  frm_ack <= 1'b1;
                  state   <= ST_DONE;
               end
            default:
               if (!frm_req)
               begin
                  frm_ack <= 1'b0;
                  state   <= ST_IDLE;
               end
         endcase
      end
   end

   // access payload, loaded as req rises
   always_ff @(posedge pclk30)
   begin
      if (state == ST_IDLE)
      begin
         mem.addr  <= src_mac[ALUT_AW-1:0];
         mem.wdata <= '{valid: 1'b1, stamp: curr_time, port: src_port, mac: src_mac};
      end
      else if (state == ST_WR_REL)
         mem.addr <= dst_mac[ALUT_AW-1:0];   // index of the lookup
      if (mem.ack && !mem.write)
         rd_entry <= mem.rdata;
   end

   // result only after the table is let go
   a_ack_after_table : assert property (@(posedge pclk30) disable iff (!n_p_reset30)
      $rose(frm_ack) |-> (!mem.req && !mem.ack));

endmodule

`default_nettype wire

/* hw/alut_age_checker.sv */
//--------------------------------------------------------------------
// time counter, age queries and the two invalidation sweeps
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker
#(
   parameter int DIV_W  = 8,
   parameter int TIME_W = alut_pkg::ALUT_TW
)
(
   input  logic                 pclk30,
   input  logic                 n_p_reset30,
   alut_mem_if.requester        mem,
   input  logic [DIV_W-1:0]     div_clk,          // clocks per tick, minus one
   input  logic [TIME_W-1:0]    best_bfr_age,
   output logic [TIME_W-1:0]    curr_time,
   input  logic                 cmd_req,
   output logic                 cmd_ack,
   input  alut_pkg::alut_cmd_e  command,
   input  logic                 age_req,
   output logic                 age_ack,
   input  logic [TIME_W-1:0]    last_accessed,
   output logic                 age_ok,           // high = in date
   output logic                 age_check_active,
   output logic                 inval_in_prog,
   output logic [47:0]          lst_inv_addr,
   output logic [1:0]           lst_inv_port
);
   import alut_pkg::*;

   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_QUERY  = 3'd1;   // age_ack high
   localparam logic [2:0] ST_RD     = 3'd2;   // sweep read in flight
   localparam logic [2:0] ST_RD_REL = 3'd3;
   localparam logic [2:0] ST_WR     = 3'd4;   // clearing write in flight
   localparam logic [2:0] ST_WR_REL = 3'd5;
   localparam logic [2:0] ST_DONE   = 3'd6;   // cmd_ack high

   logic [2:0]          state;
   logic [DIV_W-1:0]    div_cnt;      // clock divider
   logic [ALUT_AW-1:0]  sweep_addr;   // word under inspection
   logic                all_mode;     // sweep clears every word
   alut_entry_t         rd_entry;     // word read by the aged sweep
   logic                rd_aged;      // valid and past its age
   logic                last_word;

   // in date while elapsed time, modulo 2^TIME_W, is under best_bfr_age
   function automatic logic in_date(input logic [TIME_W-1:0] stamp);
      logic [TIME_W-1:0] elapsed;
      elapsed = curr_time - stamp;
      return best_bfr_age > elapsed;
   endfunction

   assign rd_aged          = rd_entry.valid && !in_date(TIME_W'(rd_entry.stamp));
   assign last_word        = &sweep_addr;
   assign age_check_active = (state != ST_IDLE);
   assign mem.addr         = sweep_addr;
   assign mem.wdata        = '0;            // only ever clears words

   //--------------------------------------------------------------------
   // time base
   //--------------------------------------------------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt == div_clk)
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   //--------------------------------------------------------------------
   // query and sweep FSM
   //--------------------------------------------------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         state         <= ST_IDLE;
         mem.req       <= 1'b0;
         mem.write     <= 1'b0;
         cmd_ack       <= 1'b0;
         age_ack       <= 1'b0;
         age_ok        <= 1'b0;
         inval_in_prog <= 1'b0;
         all_mode      <= 1'b0;
         sweep_addr    <= '0;
         lst_inv_addr  <= '0;
         lst_inv_port  <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (age_req)
               begin
                  age_ack <= 1'b1;             // queries go ahead of commands
                  age_ok  <= in_date(last_accessed);
                  state   <= ST_QUERY;
               end
               else if (cmd_req)
               begin
                  sweep_addr <= '0;
                  all_mode   <= (command == cmd_inval_all);
                  case (command)
                     cmd_inval_aged:
                     begin
                        mem.req <= 1'b1;
                        state   <= ST_RD;
                     end
                     cmd_inval_all:
                     begin
                        mem.req   <= 1'b1;
                        mem.write <= 1'b1;
                        state     <= ST_WR;
                     end
                     default:
                     begin
                        cmd_ack <= 1'b1;       // none or reserved, nothing to do
                        state   <= ST_DONE;
                     end
                  endcase
               end
            ST_QUERY:
               if (!age_req)
               begin
                  age_ack <= 1'b0;
                  state   <= ST_IDLE;
               end
            ST_RD, ST_WR:
               if (mem.ack)
               begin
                  mem.req <= 1'b0;
                  state   <= state + 3'd1;     // matching release state
               end
            ST_RD_REL:
               if (!mem.ack)
               begin
                  if (rd_aged)
                  begin
                     mem.req       <= 1'b1;    // clear this one
                     mem.write     <= 1'b1;
                     inval_in_prog <= 1'b1;
                     lst_inv_addr  <= rd_entry.mac;
                     lst_inv_port  <= rd_entry.port;
                     state         <= ST_WR;
                  end
                  else if (last_word)
                  begin
                     inval_in_prog <= 1'b0;
                     cmd_ack       <= 1'b1;
                     state         <= ST_DONE;
                  end
                  else
                  begin
                     sweep_addr <= sweep_addr + 1'b1;
                     mem.req    <= 1'b1;
                     state      <= ST_RD;
                  end
               end
            ST_WR_REL:
               if (!mem.ack)
               begin
                  if (last_word)
                  begin
                     inval_in_prog <= 1'b0;
                     mem.write     <= 1'b0;
                     cmd_ack       <= 1'b1;
                     state         <= ST_DONE;
                  end
                  else
                  begin
                     sweep_addr <= sweep_addr + 1'b1;
                     mem.req    <= 1'b1;
                     mem.write  <= all_mode;   // aged sweep reads next word
                     state      <= all_mode ? ST_WR : ST_RD;
                  end
               end
            default:
               if (!cmd_req)
               begin
                  cmd_ack <= 1'b0;
                  state   <= ST_IDLE;
               end
         endcase
      end
   end

   // sweep read data
   always_ff @(posedge pclk30)
   begin
      if (mem.ack && !mem.write)
         rd_entry <= mem.rdata;
   end

   // aged sweep only clears a word it has just read as out of date
   a_aged_write : assert property (@(posedge pclk30) disable iff (!n_p_reset30)
      ($rose(mem.req) && mem.write && !all_mode) |-> $past(rd_aged));

endmodule

`default_nettype wire

/* hw/alut_arbiter.sv */
//--------------------------------------------------------------------
// fixed-priority arbiter, address checker ahead of age checker
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_arbiter
(
   input  logic           pclk30,
   input  logic           n_p_reset30,
   alut_mem_if.responder  ac,        // address checker, high priority
   alut_mem_if.responder  ag,        // age checker
   alut_mem_if.requester  tbl        // toward the table
);

   localparam logic [1:0] OWN_NONE = 2'd0;
   localparam logic [1:0] OWN_AC   = 2'd1;
   localparam logic [1:0] OWN_AG   = 2'd2;

   logic [1:0]  owner;     // engine currently holding the table
   logic        own_req;   // req of that engine

   assign own_req = (owner == OWN_AC) ? ac.req :
                    (owner == OWN_AG) ? ag.req : 1'b0;

   //--------------------------------------------------------------------
   // owner register
   //--------------------------------------------------------------------
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
         owner <= OWN_NONE;
      else if (owner == OWN_NONE)
      begin
         if (ac.req)
            owner <= OWN_AC;                  // ac wins a tie
         else if (ag.req)
            owner <= OWN_AG;
      end
      else if (!own_req && !tbl.ack)
         owner <= OWN_NONE;                   // four-phase cycle complete
   end

   //--------------------------------------------------------------------
   // steering
   //--------------------------------------------------------------------
   assign tbl.req   = own_req;
   assign tbl.addr  = (owner == OWN_AG) ? ag.addr : ac.addr;
   assign tbl.write = (owner == OWN_AC) ? ac.write :
                      (owner == OWN_AG) ? ag.write : 1'b0;
   assign tbl.wdata = (owner == OWN_AG) ? ag.wdata : ac.wdata;

   // response goes back to the owner only
   assign ac.ack   = (owner == OWN_AC) && tbl.ack;
   assign ac.rdata = (owner == OWN_AC) ? tbl.rdata : '0;
   assign ag.ack   = (owner == OWN_AG) && tbl.ack;
   assign ag.rdata = (owner == OWN_AG) ? tbl.rdata : '0;

   // table never answers an access nobody owns
   a_ack_has_owner : assert property (@(posedge pclk30) disable iff (!n_p_reset30)
      tbl.ack |-> (owner != OWN_NONE));

endmodule

`default_nettype wire

/* hw/alut_mem_if.sv */
//--------------------------------------------------------------------
// four-phase req/ack access port to the address table
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface alut_mem_if;
   import alut_pkg::*;

   logic                req;     // requester wants the table
   logic                ack;     // access done, rdata valid while high
   logic [ALUT_AW-1:0]  addr;    // word index
   logic                write;   // 1 = write, 0 = read
   alut_entry_t         wdata;   // word to store
   alut_entry_t         rdata;   // word read back

   // engine side, addr/write/wdata steady while req is high
   modport requester
   (
      output req, addr, write, wdata,
      input  ack, rdata
   );

   // table side, one ack per req
   modport responder
   (
      input  req, addr, write, wdata,
      output ack, rdata
   );

endinterface

`default_nettype wire

/* hw/alut_pkg.sv */
//--------------------------------------------------------------------
// table word layout, command bus codes and table geometry
//--------------------------------------------------------------------
`default_nettype none

package alut_pkg;

   // table geometry
   localparam int ALUT_AW    = 8;               // index width, low mac byte
   localparam int ALUT_DEPTH = 1 << ALUT_AW;    // 256 words
   localparam int ALUT_TW    = 32;              // time counter and stamp width

   // one table word, 83 bits, valid on top
   typedef struct packed
   {
      logic                valid;   // entry holds a learned address
      logic [ALUT_TW-1:0]  stamp;   // curr_time when last learned
      logic [1:0]          port;    // switch port the mac came in on
      logic [47:0]         mac;     // learned source mac
   } alut_entry_t;

   // command bus, 2'd1 is reserved
   typedef enum logic [1:0]
   {
      cmd_none       = 2'd0,
      cmd_inval_aged = 2'd2,       // clear entries past best-before age
      cmd_inval_all  = 2'd3        // clear the whole table
   } alut_cmd_e;

endpackage

`default_nettype wire

/* hw/alut_table.sv */
//--------------------------------------------------------------------
// 256-word address table behind a four-phase access port
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_table
(
   input  logic           pclk30,
   input  logic           n_p_reset30,
   alut_mem_if.responder  bus
);
   import alut_pkg::*;

   alut_entry_t  mem [ALUT_DEPTH];   // table words

   // access happens on the req rise, ack drops once req is gone
   always_ff @(posedge pclk30 or negedge n_p_reset30)
   begin
      if (!n_p_reset30)
      begin
         bus.ack <= 1'b0;
         for (int i = 0; i < ALUT_DEPTH; i++)
            mem[i] <= '0;                     // whole table invalid
      end
      else if (bus.req && !bus.ack)
      begin
         bus.ack <= 1'b1;
         if (bus.write)
            mem[bus.addr] <= bus.wdata;
      end
      else if (!bus.req && bus.ack)
         bus.ack <= 1'b0;
   end

   // read word, stays put while ack is high
   always_ff @(posedge pclk30)
   begin
      if (bus.req && !bus.ack && !bus.write)
         bus.rdata <= mem[bus.addr];
   end

   // requester keeps req up until the ack arrives
   a_ack_needs_req : assert property (@(posedge pclk30) disable iff (!n_p_reset30)
      $rose(bus.ack) |-> bus.req);

endmodule

`default_nettype wire

/* hw/alut_top.sv */
//--------------------------------------------------------------------
// lookup table top: engines, arbiter and table on plain ports
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_top
#(
   parameter int DIV_W  = 8,
   parameter int TIME_W = alut_pkg::ALUT_TW
)
(
   input  logic                 pclk30,
   input  logic                 n_p_reset30,
   // frames
   input  logic                 frm_req,
   output logic                 frm_ack,
   input  logic [47:0]          src_mac,
   input  logic [1:0]           src_port,
   input  logic [47:0]          dst_mac,
   output logic                 dst_hit,
   output logic [1:0]           dst_port,
   // time base
   input  logic [DIV_W-1:0]     div_clk,
   input  logic [TIME_W-1:0]    best_bfr_age,
   output logic [TIME_W-1:0]    curr_time,
   // commands and status
   input  logic                 cmd_req,
   output logic                 cmd_ack,
   input  alut_pkg::alut_cmd_e  command,
   output logic                 age_check_active,
   output logic                 inval_in_prog,
   output logic [47:0]          lst_inv_addr,
   output logic [1:0]           lst_inv_port
);

   logic                age_req;         // age query between the engines
   logic                age_ack;
   logic [TIME_W-1:0]   last_accessed;
   logic                age_ok;

   alut_mem_if ac_if ();                 // address checker to arbiter
   alut_mem_if ag_if ();                 // age checker to arbiter
   alut_mem_if tb_if ();                 // arbiter to table

   alut_addr_checker u_addr_checker
   (
      .pclk30        (pclk30),
      .n_p_reset30   (n_p_reset30),
      .mem           (ac_if.requester),
      .frm_req       (frm_req),
      .frm_ack       (frm_ack),
      .src_mac       (src_mac),
      .src_port      (src_port),
      .dst_mac       (dst_mac),
      .dst_hit       (dst_hit),
      .dst_port      (dst_port),
      .curr_time     (curr_time),
      .age_req       (age_req),
      .age_ack       (age_ack),
      .last_accessed (last_accessed),
      .age_ok        (age_ok)
   );

   alut_age_checker #(.DIV_W(DIV_W), .TIME_W(TIME_W)) u_age_checker
   (
      .pclk30           (pclk30),
      .n_p_reset30      (n_p_reset30),
      .mem              (ag_if.requester),
      .div_clk          (div_clk),
      .best_bfr_age     (best_bfr_age),
      .curr_time        (curr_time),
      .cmd_req          (cmd_req),
      .cmd_ack          (cmd_ack),
      .command          (command),
      .age_req          (age_req),
      .age_ack          (age_ack),
      .last_accessed    (last_accessed),
      .age_ok           (age_ok),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   alut_arbiter u_arbiter
   (
      .pclk30      (pclk30),
      .n_p_reset30 (n_p_reset30),
      .ac          (ac_if.responder),
      .ag          (ag_if.responder),
      .tbl         (tb_if.requester)
   );

   alut_table u_table
   (
      .pclk30      (pclk30),
      .n_p_reset30 (n_p_reset30),
      .bus         (tb_if.responder)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the lookup table testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module alut_tb \
   -f sim.f -o alut_sim

./obj_dir/alut_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
   exit 1
fi
exit 0

/* sim.f */
hw/alut_pkg.sv
hw/alut_mem_if.sv
hw/alut_table.sv
hw/alut_arbiter.sv
hw/alut_addr_checker.sv
hw/alut_age_checker.sv
hw/alut_top.sv
tests/alut_tb.sv

/* tests/alut_tb.sv */
//----------------------------------------------------------------------
// directed testbench for the address lookup table: learn, lookup,
// aging, both invalidation sweeps and frame/sweep contention
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alut_tb;
   import alut_pkg::*;

   localparam int DIV_W   = 8;
   localparam int TIME_W  = ALUT_TW;
   localparam int TIMEOUT = 10000;              // clocks per handshake wait
   localparam logic [TIME_W-1:0] AGE_MAX = '1;  // nothing ever out of date

   logic                pclk30;
   logic                n_p_reset30;
   logic                frm_req;
   logic                frm_ack;
   logic [47:0]         src_mac;
   logic [1:0]          src_port;
   logic [47:0]         dst_mac;
   logic                dst_hit;
   logic [1:0]          dst_port;
   logic [DIV_W-1:0]    div_clk;
   logic [TIME_W-1:0]   best_bfr_age;
   logic [TIME_W-1:0]   curr_time;
   logic                cmd_req;
   logic                cmd_ack;
   alut_cmd_e           command;
   logic                age_check_active;
   logic                inval_in_prog;
   logic [47:0]         lst_inv_addr;
   logic [1:0]          lst_inv_port;

   int          mismatch_cnt;
   int          fail_cnt;
   integer      seed;
   logic        used [256];    // low mac bytes already handed out
   logic [47:0] probe;         // source mac of every lookup frame

   alut_top #(.DIV_W(DIV_W), .TIME_W(TIME_W)) dut0
   (
      .pclk30           (pclk30),
      .n_p_reset30      (n_p_reset30),
      .frm_req          (frm_req),
      .frm_ack          (frm_ack),
      .src_mac          (src_mac),
      .src_port         (src_port),
      .dst_mac          (dst_mac),
      .dst_hit          (dst_hit),
      .dst_port         (dst_port),
      .div_clk          (div_clk),
      .best_bfr_age     (best_bfr_age),
      .curr_time        (curr_time),
      .cmd_req          (cmd_req),
      .cmd_ack          (cmd_ack),
      .command          (command),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   initial
   begin
      pclk30 = 1'b0;
      forever #20 pclk30 = ~pclk30;            // 40 ns period
   end

   //----------------------------------------------------------------------
   // helpers
   //----------------------------------------------------------------------
   task automatic tick();
      @(posedge pclk30);
      #2;                                       // drive and sample point
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         fail_cnt++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   // random mac whose low byte (the table index) is not yet taken
   task automatic pick_mac(output logic [47:0] mac);
      logic [31:0] hi;
      logic [31:0] lo;
      do
      begin
         hi  = $random(seed);
         lo  = $random(seed);
         mac = {hi[15:0], lo};
      end
      while (used[mac[7:0]]);
      used[mac[7:0]] = 1'b1;
   endtask

   // one four-phase frame, result captured while frm_ack is high
   task automatic run_frame(input logic [47:0] src, input logic [1:0] port,
                            input logic [47:0] dst, output logic hit,
                            output logic [1:0] hit_port);
      int n;
      src_mac  = src;
      src_port = port;
      dst_mac  = dst;
      frm_req  = 1'b1;
      n = 0;
      while (frm_ack !== 1'b1 && n < TIMEOUT)
      begin
         tick();
         n++;
      end
      check_true(frm_ack, "frame was not acknowledged within the timeout");
      hit      = dst_hit;
      hit_port = dst_port;
      frm_req  = 1'b0;
      n = 0;
      while (frm_ack !== 1'b0 && n < TIMEOUT)
      begin
         tick();
         n++;
      end
      check_true(!frm_ack, "frm_ack stayed high after frm_req fell");
      tick();
   endtask

   task automatic learn(input logic [47:0] mac, input logic [1:0] port);
      logic       h;
      logic [1:0] p;
      run_frame(mac, port, mac, h, p);          // dst = src, result unused
   endtask

   task automatic lookup(input logic [47:0] dst, input logic exp_hit,
                         input logic [1:0] exp_port);
      logic       h;
      logic [1:0] p;
      run_frame(probe, 2'd0, dst, h, p);
      check_val("dst_hit", h, exp_hit);
      if (exp_hit)
         check_val("dst_port", p, exp_port);
   endtask

   // four-phase command, watching the status flags on the way
   task automatic run_command(input alut_cmd_e cmd, output logic saw_prog,
                              output logic saw_active);
      int n;
      command    = cmd;
      cmd_req    = 1'b1;
      saw_prog   = 1'b0;
      saw_active = 1'b0;
      n = 0;
      while (cmd_ack !== 1'b1 && n < TIMEOUT)
      begin
         tick();
         if (inval_in_prog === 1'b1)
            saw_prog = 1'b1;
         if (age_check_active === 1'b1 && cmd_ack !== 1'b1)
            saw_active = 1'b1;                  // only counts before the ack
         n++;
      end
      check_true(cmd_ack, "command was not acknowledged within the timeout");
      cmd_req = 1'b0;
      n = 0;
      while (cmd_ack !== 1'b0 && n < TIMEOUT)
      begin
         tick();
         n++;
      end
      check_true(!cmd_ack, "cmd_ack stayed high after cmd_req fell");
      command = cmd_none;
      tick();
   endtask

   // advance until at least gap ticks have passed since t0
   task automatic wait_time(input logic [TIME_W-1:0] t0, input int gap);
      int n;
      n = 0;
      while ((curr_time - t0) < TIME_W'(gap) && n < TIMEOUT)
      begin
         tick();
         n++;
      end
      check_true((curr_time - t0) >= TIME_W'(gap), "time counter did not advance");
   endtask

   //----------------------------------------------------------------------
   // directed tests
   //----------------------------------------------------------------------
   // div_clk is 0, so one time step per clock
   task automatic test_time_base();
      logic [TIME_W-1:0] t0;
      t0 = curr_time;
      repeat (10) tick();
      check_val("curr_time", curr_time, t0 + TIME_W'(10));
   endtask

   task automatic test_learn_hit();
      logic [47:0] a;
      pick_mac(a);
      best_bfr_age = AGE_MAX;
      learn(a, 2'd2);
      lookup(a, 1'b1, 2'd2);
   endtask

   task automatic test_miss();
      logic [47:0] a;
      logic [47:0] never;
      pick_mac(a);
      pick_mac(never);
      learn(a, 2'd1);
      lookup(never, 1'b0, 2'd0);                // index never written
      lookup({~a[47:8], a[7:0]}, 1'b0, 2'd0);  // same index, other mac
   endtask

   task automatic test_aging_lookup();
      logic [47:0]       a;
      logic [TIME_W-1:0] t0;
      pick_mac(a);
      best_bfr_age = 20;
      learn(a, 2'd3);
      t0 = curr_time;
      wait_time(t0, 20);
      lookup(a, 1'b0, 2'd0);                    // too old now
      best_bfr_age = AGE_MAX;
      lookup(a, 1'b1, 2'd3);
   endtask

   task automatic test_inval_aged();
      logic [47:0]       b;
      logic [47:0]       c;
      logic [TIME_W-1:0] t0;
      logic              prog;
      logic              act;
      best_bfr_age = AGE_MAX;
      run_command(cmd_inval_all, prog, act);    // start from an empty table
      pick_mac(b);
      pick_mac(c);
      learn(b, 2'd1);
      t0 = curr_time;
      wait_time(t0, 4000);
      best_bfr_age = 3000;                      // b is past it, c will not be
      learn(c, 2'd3);
      run_command(cmd_inval_aged, prog, act);
      check_val("lst_inv_addr", lst_inv_addr, b);
      check_val("lst_inv_port", lst_inv_port, 2'd1);
      check_true(prog, "inval_in_prog never rose during the aged sweep");
      check_val("inval_in_prog", inval_in_prog, 1'b0);
      best_bfr_age = AGE_MAX;
      lookup(b, 1'b0, 2'd0);
      lookup(c, 1'b1, 2'd3);
   endtask

   task automatic test_inval_all();
      logic [47:0] m [4];
      logic        prog;
      logic        act;
      best_bfr_age = AGE_MAX;
      for (int i = 0; i < 4; i++)
      begin
         pick_mac(m[i]);
         learn(m[i], 2'(i));
      end
      run_command(cmd_inval_all, prog, act);
      check_true(act, "age_check_active not seen high before cmd_ack");
      for (int i = 0; i < 4; i++)
         lookup(m[i], 1'b0, 2'd0);
   endtask

   task automatic test_contention();
      logic [47:0] d;
      logic        prog;
      logic        act;
      pick_mac(d);
      best_bfr_age = AGE_MAX;
      learn(d, 2'd1);
      fork
         run_command(cmd_inval_aged, prog, act);
         begin
            repeat (20) tick();
            check_true(age_check_active, "sweep not running when the frame was sent");
            lookup(d, 1'b1, 2'd1);              // query waits out the sweep
         end
      join
   endtask

   //----------------------------------------------------------------------
   // main sequence
   //----------------------------------------------------------------------
   initial
   begin
      mismatch_cnt = 0;
      fail_cnt     = 0;
      seed         = 32'h6de9_dd6b;
      for (int i = 0; i < 256; i++)
         used[i] = 1'b0;
      n_p_reset30  = 1'b0;
      frm_req      = 1'b0;
      src_mac      = '0;
      src_port     = '0;
      dst_mac      = '0;
      div_clk      = '0;                        // time advances every clock
      best_bfr_age = AGE_MAX;
      cmd_req      = 1'b0;
      command      = cmd_none;
      pick_mac(probe);
      repeat (16) tick();
      check_val("curr_time", curr_time, '0);   // held at zero in reset
      n_p_reset30 = 1'b1;
      tick();

      test_time_base();
      test_learn_hit();
      test_miss();
      test_aging_lookup();
      test_inval_aged();
      test_inval_all();
      test_contention();

      $display("done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
